// ==== common/apb_sub_config.svh ====
`ifndef APB_SUB_CONFIG_SVH
`define APB_SUB_CONFIG_SVH

// Bus widths
`define APB_SUB_ADDR_W 12
`define APB_SUB_DATA_W 32

// Peripheral sizes
`define APB_SUB_NUM_GPIO 8
`define APB_SUB_NUM_PWM 4

// Address map, every region has the same size
`define APB_SUB_GPIO_BASE 'h000
`define APB_SUB_PWM_BASE 'h100
`define APB_SUB_REG_BASE 'h200
`define APB_SUB_REGION_SIZE 'h100

`endif

// ==== common/apb_sub_pkg.sv ====
`include "apb_sub_config.svh"

package apb_sub_pkg;

   typedef logic [`APB_SUB_ADDR_W-1:0] addr_t;
   typedef logic [`APB_SUB_DATA_W-1:0] data_t;

   // Host request port
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  write;
   } host_req_t;

   typedef struct packed {
      data_t rdata;
      logic  error;
   } host_rsp_t;

   // APB master to slave
   typedef struct packed {
      addr_t paddr;
      data_t pwdata;
      logic  pwrite;
      logic  psel;
      logic  penable;
   } apb_req_t;

   // APB slave to master
   typedef struct packed {
      data_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

   // External pad-configuration bus
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  write;
      logic  valid;
   } reg_req_t;

   typedef struct packed {
      data_t rdata;
      logic  error;
      logic  ready;
   } reg_rsp_t;

endpackage

// ==== filelist.f ====
+incdir+common
common/apb_sub_pkg.sv
src/apb_master_bridge.sv
src/periph_bus_decoder.sv
gpio/apb_gpio.sv
pwm/apb_pwm_timer.sv
src/apb_to_reg.sv
src/apb_subsystem.sv
testbench/apb_subsystem_properties.sv
testbench/tb_apb_subsystem.sv

// ==== gpio/apb_gpio.sv ====
`timescale 1ns/1ns
`include "apb_sub_config.svh"

module apb_gpio (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  apb_sub_pkg::apb_req_t        apb_req_i,
   output apb_sub_pkg::apb_rsp_t        apb_rsp_o,
   input  logic [`APB_SUB_NUM_GPIO-1:0] gpio_i,
   output logic [`APB_SUB_NUM_GPIO-1:0] gpio_o,
   output logic [`APB_SUB_NUM_GPIO-1:0] gpio_dir_o
);

   localparam int NUM_GPIO = `APB_SUB_NUM_GPIO;
   localparam int OFFS_W   = $clog2(`APB_SUB_REGION_SIZE);

   localparam logic [OFFS_W-1:0] REG_DIR = 'h0;
   localparam logic [OFFS_W-1:0] REG_OUT = 'h4;
   localparam logic [OFFS_W-1:0] REG_IN  = 'h8;

   logic [OFFS_W-1:0]   offset;
   logic                access;
   logic                wr_en;
   logic [NUM_GPIO-1:0] dir_q;
   logic [NUM_GPIO-1:0] out_q;
   logic [NUM_GPIO-1:0] sync_q;
   logic [NUM_GPIO-1:0] in_q;

   assign offset = apb_req_i.paddr[OFFS_W-1:0];
   assign access = apb_req_i.psel & apb_req_i.penable;
   assign wr_en  = access & apb_req_i.pwrite;

   assign gpio_o     = out_q;
   assign gpio_dir_o = dir_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dir_q  <= '0;
         out_q  <= '0;
         sync_q <= '0;
         in_q   <= '0;
      end else begin
         // two flops against metastability on the pad inputs
         sync_q <= gpio_i;
         in_q   <= sync_q;
         if (wr_en) begin
            case (offset)
               REG_DIR: dir_q <= apb_req_i.pwdata[NUM_GPIO-1:0];
               REG_OUT: out_q <= apb_req_i.pwdata[NUM_GPIO-1:0];
               default: ;
            endcase
         end
      end
   end

   // No wait states
   always_comb begin
      apb_rsp_o.prdata  = '0;
      apb_rsp_o.pready  = access;
      apb_rsp_o.pslverr = 1'b0;
      case (offset)
         REG_DIR: apb_rsp_o.prdata = apb_sub_pkg::data_t'(dir_q);
         REG_OUT: apb_rsp_o.prdata = apb_sub_pkg::data_t'(out_q);
         REG_IN: begin
            apb_rsp_o.prdata  = apb_sub_pkg::data_t'(in_q);
            apb_rsp_o.pslverr = wr_en;
         end
         default: apb_rsp_o.pslverr = access;
      endcase
   end

endmodule

// ==== pwm/apb_pwm_timer.sv ====
`timescale 1ns/1ns
`include "apb_sub_config.svh"

module apb_pwm_timer (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  apb_sub_pkg::apb_req_t       apb_req_i,
   output apb_sub_pkg::apb_rsp_t       apb_rsp_o,
   output logic [`APB_SUB_NUM_PWM-1:0] pwm_o
);

   localparam int NUM_CH = `APB_SUB_NUM_PWM;
   localparam int OFFS_W = $clog2(`APB_SUB_REGION_SIZE);
   localparam int CH_W   = $clog2(NUM_CH);

   localparam logic [OFFS_W-1:0] REG_ENABLE = 'hF0;

   logic [OFFS_W-1:0]  offset;
   logic [CH_W-1:0]    ch_sel;
   logic               access;
   logic               wr_en;
   logic               is_ch;
   logic               is_en;
   logic               enable_q;
   apb_sub_pkg::data_t period_q [NUM_CH];
   apb_sub_pkg::data_t duty_q   [NUM_CH];
   apb_sub_pkg::data_t cnt_q    [NUM_CH];

   // Channel n sits at 8n (period) and 8n+4 (duty)
   assign offset = apb_req_i.paddr[OFFS_W-1:0];
   assign ch_sel = offset[3 +: CH_W];
   assign is_ch  = (offset[1:0] == 2'b00) && (offset[OFFS_W-1:3] < NUM_CH);
   assign is_en  = (offset == REG_ENABLE);
   assign access = apb_req_i.psel & apb_req_i.penable;
   assign wr_en  = access & apb_req_i.pwrite;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         enable_q <= 1'b0;
         for (int n = 0; n < NUM_CH; n++) begin
            period_q[n] <= '0;
            duty_q[n]   <= '0;
         end
      end else if (wr_en) begin
         if (is_en) begin
            enable_q <= apb_req_i.pwdata[0];
         end else if (is_ch && offset[2]) begin
            duty_q[ch_sel] <= apb_req_i.pwdata;
         end else if (is_ch) begin
            period_q[ch_sel] <= apb_req_i.pwdata;
         end
      end
   end

   // Counters free-run 0 .. period-1 and sit at zero while disabled
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int n = 0; n < NUM_CH; n++) begin
            cnt_q[n] <= '0;
         end
      end else begin
         for (int n = 0; n < NUM_CH; n++) begin
            if (!enable_q || (period_q[n] == '0) || (cnt_q[n] >= period_q[n] - 1'b1)) begin
               cnt_q[n] <= '0;
            end else begin
               cnt_q[n] <= cnt_q[n] + 1'b1;
            end
         end
      end
   end

   // duty >= period gives a constant high output
   always_comb begin
      for (int n = 0; n < NUM_CH; n++) begin
         pwm_o[n] = enable_q && (period_q[n] != '0) && (cnt_q[n] < duty_q[n]);
      end
   end

   always_comb begin
      apb_rsp_o.pready  = access;
      apb_rsp_o.pslverr = access && !(is_ch || is_en);
      apb_rsp_o.prdata  = '0;
      if (is_en) begin
         apb_rsp_o.prdata = apb_sub_pkg::data_t'(enable_q);
      end else if (is_ch) begin
         apb_rsp_o.prdata = offset[2] ? duty_q[ch_sel] : period_q[ch_sel];
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module tb_apb_subsystem -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1

// ==== src/apb_master_bridge.sv ====
`timescale 1ns/1ns

module apb_master_bridge (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   input  apb_sub_pkg::host_req_t req_i,
   output logic                   rsp_valid_o,
   input  logic                   rsp_ready_i,
   output apb_sub_pkg::host_rsp_t rsp_o,
   output apb_sub_pkg::apb_req_t  apb_req_o,
   input  apb_sub_pkg::apb_rsp_t  apb_rsp_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS,
      ST_RESPOND
   } state_t;

   state_t                 state_q;
   apb_sub_pkg::host_req_t req_q;
   apb_sub_pkg::host_rsp_t rsp_q;

   // Only one transfer in flight, new requests wait for the response handshake
   assign req_ready_o = (state_q == ST_IDLE);
   assign rsp_valid_o = (state_q == ST_RESPOND);
   assign rsp_o       = rsp_q;

   always_comb begin
      apb_req_o.paddr   = req_q.addr;
      apb_req_o.pwdata  = req_q.wdata;
      apb_req_o.pwrite  = req_q.write;
      apb_req_o.psel    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
      apb_req_o.penable = (state_q == ST_ACCESS);
   end

   // Setup, access, then the response in the third cycle after acceptance
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (req_valid_i) begin
                  state_q <= ST_SETUP;
               end
            end
            ST_SETUP: begin
               state_q <= ST_ACCESS;
            end
            ST_ACCESS: begin
               // slow slaves stretch the access phase here
               if (apb_rsp_i.pready) begin
                  state_q <= ST_RESPOND;
               end
            end
            default: begin
               if (rsp_ready_i) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_i && req_ready_o) begin
         req_q <= req_i;
      end
      if ((state_q == ST_ACCESS) && apb_rsp_i.pready) begin
         rsp_q.rdata <= apb_rsp_i.prdata;
         rsp_q.error <= apb_rsp_i.pslverr;
      end
   end

endmodule

// ==== src/apb_subsystem.sv ====
`timescale 1ns/1ns
`include "apb_sub_config.svh"

module apb_subsystem (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          req_valid_i,
   output logic                          req_ready_o,
   input  apb_sub_pkg::host_req_t        req_i,
   output logic                          rsp_valid_o,
   input  logic                          rsp_ready_i,
   output apb_sub_pkg::host_rsp_t        rsp_o,
   input  logic [`APB_SUB_NUM_GPIO-1:0]  gpio_i,
   output logic [`APB_SUB_NUM_GPIO-1:0]  gpio_o,
   output logic [`APB_SUB_NUM_GPIO-1:0]  gpio_dir_o,
   output logic [`APB_SUB_NUM_PWM-1:0]   pwm_o,
   output apb_sub_pkg::reg_req_t         reg_req_o,
   input  apb_sub_pkg::reg_rsp_t         reg_rsp_i
);

   // Peripheral bus before and after the decoder
   apb_sub_pkg::apb_req_t periph_req;
   apb_sub_pkg::apb_rsp_t periph_rsp;
   apb_sub_pkg::apb_req_t gpio_req;
   apb_sub_pkg::apb_rsp_t gpio_rsp;
   apb_sub_pkg::apb_req_t pwm_req;
   apb_sub_pkg::apb_rsp_t pwm_rsp;
   apb_sub_pkg::apb_req_t padcfg_req;
   apb_sub_pkg::apb_rsp_t padcfg_rsp;

   apb_master_bridge i_apb_master_bridge (
      .clk_i       ( clk_i       ),
      .arst_n_i    ( arst_n_i    ),
      .req_valid_i ( req_valid_i ),
      .req_ready_o ( req_ready_o ),
      .req_i       ( req_i       ),
      .rsp_valid_o ( rsp_valid_o ),
      .rsp_ready_i ( rsp_ready_i ),
      .rsp_o       ( rsp_o       ),
      .apb_req_o   ( periph_req  ),
      .apb_rsp_i   ( periph_rsp  )
   );

   periph_bus_decoder i_periph_bus_decoder (
      .apb_req_i  ( periph_req ),
      .apb_rsp_o  ( periph_rsp ),
      .gpio_req_o ( gpio_req   ),
      .gpio_rsp_i ( gpio_rsp   ),
      .pwm_req_o  ( pwm_req    ),
      .pwm_rsp_i  ( pwm_rsp    ),
      .reg_req_o  ( padcfg_req ),
      .reg_rsp_i  ( padcfg_rsp )
   );

   apb_gpio i_apb_gpio (
      .clk_i      ( clk_i      ),
      .arst_n_i   ( arst_n_i   ),
      .apb_req_i  ( gpio_req   ),
      .apb_rsp_o  ( gpio_rsp   ),
      .gpio_i     ( gpio_i     ),
      .gpio_o     ( gpio_o     ),
      .gpio_dir_o ( gpio_dir_o )
   );

   apb_pwm_timer i_apb_pwm_timer (
      .clk_i     ( clk_i    ),
      .arst_n_i  ( arst_n_i ),
      .apb_req_i ( pwm_req  ),
      .apb_rsp_o ( pwm_rsp  ),
      .pwm_o     ( pwm_o    )
   );

   apb_to_reg i_apb_to_padframecfg (
      .clk_i     ( clk_i      ),
      .arst_n_i  ( arst_n_i   ),
      .apb_req_i ( padcfg_req ),
      .apb_rsp_o ( padcfg_rsp ),
      .reg_req_o ( reg_req_o  ),
      .reg_rsp_i ( reg_rsp_i  )
   );

endmodule

// ==== src/apb_to_reg.sv ====
`timescale 1ns/1ns
`include "apb_sub_config.svh"

module apb_to_reg (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  apb_sub_pkg::apb_req_t apb_req_i,
   output apb_sub_pkg::apb_rsp_t apb_rsp_o,
   output apb_sub_pkg::reg_req_t reg_req_o,
   input  apb_sub_pkg::reg_rsp_t reg_rsp_i
);

   localparam apb_sub_pkg::addr_t OFFS_MASK =
      apb_sub_pkg::addr_t'(`APB_SUB_REGION_SIZE - 1);

   logic                  access;
   logic                  pending_q;
   apb_sub_pkg::reg_req_t req_now;
   apb_sub_pkg::reg_req_t held_q;

   assign access = apb_req_i.psel & apb_req_i.penable;

   // Pad config bus sees addresses relative to its own region
   always_comb begin
      req_now.addr  = apb_req_i.paddr & OFFS_MASK;
      req_now.wdata = apb_req_i.pwdata;
      req_now.write = apb_req_i.pwrite;
      req_now.valid = access;
   end

   // Once valid is up it stays put until ready, whatever the APB side does
   assign reg_req_o = pending_q ? held_q : req_now;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pending_q <= 1'b0;
      end else begin
         pending_q <= reg_req_o.valid && !reg_rsp_i.ready;
      end
   end

   always_ff @(posedge clk_i) begin
      if (access && !pending_q) begin
         held_q <= req_now;
      end
   end

   always_comb begin
      apb_rsp_o.prdata  = reg_rsp_i.rdata;
      apb_rsp_o.pready  = access && reg_rsp_i.ready;
      apb_rsp_o.pslverr = access && reg_rsp_i.ready && reg_rsp_i.error;
   end

endmodule

// ==== src/periph_bus_decoder.sv ====
`timescale 1ns/1ns
`include "apb_sub_config.svh"

module periph_bus_decoder (
   input  apb_sub_pkg::apb_req_t apb_req_i,
   output apb_sub_pkg::apb_rsp_t apb_rsp_o,
   output apb_sub_pkg::apb_req_t gpio_req_o,
   input  apb_sub_pkg::apb_rsp_t gpio_rsp_i,
   output apb_sub_pkg::apb_req_t pwm_req_o,
   input  apb_sub_pkg::apb_rsp_t pwm_rsp_i,
   output apb_sub_pkg::apb_req_t reg_req_o,
   input  apb_sub_pkg::apb_rsp_t reg_rsp_i
);

   logic hit_gpio;
   logic hit_pwm;
   logic hit_reg;

   function automatic logic in_region(input apb_sub_pkg::addr_t addr,
                                      input apb_sub_pkg::addr_t base);
      apb_sub_pkg::addr_t limit;
      limit = base + apb_sub_pkg::addr_t'(`APB_SUB_REGION_SIZE);
      return (addr >= base) && (addr < limit);
   endfunction

   assign hit_gpio = in_region(apb_req_i.paddr, apb_sub_pkg::addr_t'(`APB_SUB_GPIO_BASE));
   assign hit_pwm  = in_region(apb_req_i.paddr, apb_sub_pkg::addr_t'(`APB_SUB_PWM_BASE));
   assign hit_reg  = in_region(apb_req_i.paddr, apb_sub_pkg::addr_t'(`APB_SUB_REG_BASE));

   // Same bus to every slave, psel only on the addressed one
   always_comb begin
      gpio_req_o      = apb_req_i;
      gpio_req_o.psel = apb_req_i.psel & hit_gpio;
      pwm_req_o       = apb_req_i;
      pwm_req_o.psel  = apb_req_i.psel & hit_pwm;
      reg_req_o       = apb_req_i;
      reg_req_o.psel  = apb_req_i.psel & hit_reg;
   end

   always_comb begin
      if (hit_gpio) begin
         apb_rsp_o = gpio_rsp_i;
      end else if (hit_pwm) begin
         apb_rsp_o = pwm_rsp_i;
      end else if (hit_reg) begin
         apb_rsp_o = reg_rsp_i;
      end else begin
         // Unmapped hole answers at once with an error
         apb_rsp_o.prdata  = '0;
         apb_rsp_o.pready  = 1'b1;
         apb_rsp_o.pslverr = 1'b1;
      end
   end

endmodule

// ==== testbench/apb_subsystem_properties.sv ====
`timescale 1ns/1ns

module apb_subsystem_properties (
   input logic                   clk_i,
   input logic                   arst_n_i,
   input logic                   psel_i,
   input logic                   penable_i,
   input logic                   req_ready_i,
   input logic                   rsp_valid_i,
   input logic                   rsp_ready_i,
   input apb_sub_pkg::host_rsp_t rsp_i
);

   // Access phase only follows a setup cycle
   penable_after_setup: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(penable_i) |-> psel_i && $past(psel_i))
      else $error("penable rose without a preceding setup cycle");

   rsp_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
      else $error("response changed while back-pressured");

   no_accept_while_rsp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rsp_valid_i |-> !req_ready_i)
      else $error("req_ready_o high while a response is pending");

endmodule

bind apb_subsystem apb_subsystem_properties i_apb_subsystem_properties (
   .clk_i       ( clk_i              ),
   .arst_n_i    ( arst_n_i           ),
   .psel_i      ( periph_req.psel    ),
   .penable_i   ( periph_req.penable ),
   .req_ready_i ( req_ready_o        ),
   .rsp_valid_i ( rsp_valid_o        ),
   .rsp_ready_i ( rsp_ready_i        ),
   .rsp_i       ( rsp_o              )
);

// ==== testbench/tb_apb_subsystem.sv ====
`timescale 1ns/1ns
`include "apb_sub_config.svh"

module tb_apb_subsystem;

   // About 200 cycles of tests with a wide margin
   localparam int MAX_CYCLES = 4000;
   localparam int NUM_GPIO   = `APB_SUB_NUM_GPIO;
   localparam int NUM_PWM    = `APB_SUB_NUM_PWM;

   logic                   clk;
   logic                   arst_n;
   logic                   req_valid;
   logic                   req_ready;
   apb_sub_pkg::host_req_t req;
   logic                   rsp_valid;
   logic                   rsp_ready;
   apb_sub_pkg::host_rsp_t rsp;
   logic [NUM_GPIO-1:0]    gpio_in;
   logic [NUM_GPIO-1:0]    gpio_out;
   logic [NUM_GPIO-1:0]    gpio_dir;
   logic [NUM_PWM-1:0]     pwm;
   apb_sub_pkg::reg_req_t  reg_req;
   apb_sub_pkg::reg_rsp_t  reg_rsp;

   int                     value_errs;
   int                     other_errs;
   int                     cycle_cnt;
   integer                 seed;
   int                     reg_delay;
   logic                   reg_busy;
   apb_sub_pkg::data_t     reg_rdata_model;
   logic                   reg_err_model;

   apb_subsystem uut (
      .clk_i       ( clk       ),
      .arst_n_i    ( arst_n    ),
      .req_valid_i ( req_valid ),
      .req_ready_o ( req_ready ),
      .req_i       ( req       ),
      .rsp_valid_o ( rsp_valid ),
      .rsp_ready_i ( rsp_ready ),
      .rsp_o       ( rsp       ),
      .gpio_i      ( gpio_in   ),
      .gpio_o      ( gpio_out  ),
      .gpio_dir_o  ( gpio_dir  ),
      .pwm_o       ( pwm       ),
      .reg_req_o   ( reg_req   ),
      .reg_rsp_i   ( reg_rsp   )
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // Pad config bus model that answers after 0 to 4 wait cycles
   always @(posedge clk) begin
      #10;
      if (reg_rsp.ready) begin
         reg_rsp  = '0;
         reg_busy = 1'b0;
      end else if (reg_req.valid) begin
         if (!reg_busy) begin
            reg_busy  = 1'b1;
            reg_delay = $unsigned($random(seed)) % 5;
         end else begin
            reg_delay = reg_delay - 1;
         end
         if (reg_delay == 0) begin
            reg_rsp.ready = 1'b1;
            reg_rsp.rdata = reg_rdata_model;
            reg_rsp.error = reg_err_model;
         end
      end
   end

   task automatic check_data(input string name, input apb_sub_pkg::data_t exp,
                             input apb_sub_pkg::data_t act);
      if (act !== exp) begin
         $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_error(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_reg_req(input string name, input apb_sub_pkg::reg_req_t exp,
                                input apb_sub_pkg::reg_req_t act);
      if (act !== exp) begin
         $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_pwm(input string name, input logic [NUM_PWM-1:0] exp,
                            input logic [NUM_PWM-1:0] act);
      if (act !== exp) begin
         $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
         value_errs++;
      end
   endtask

   // Called 10 ns after a rising edge, returns 10 ns after the accepting edge
   task automatic send_request(input apb_sub_pkg::addr_t addr, input apb_sub_pkg::data_t wdata,
                               input logic write);
      req_valid  = 1'b1;
      req.addr   = addr;
      req.wdata  = wdata;
      req.write  = write;
      @(negedge clk);
      while (!req_ready) @(negedge clk);
      @(posedge clk);
      #10;
      req_valid = 1'b0;
   endtask

   // lat counts falling edges after acceptance up to the first one with rsp_valid high
   task automatic wait_response(output apb_sub_pkg::host_rsp_t got, output int lat);
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!rsp_valid);
      got = rsp;
   endtask

   task automatic host_read(input apb_sub_pkg::addr_t addr,
                            output apb_sub_pkg::host_rsp_t got, output int lat);
      send_request(addr, '0, 1'b0);
      wait_response(got, lat);
      @(posedge clk);
      #10;
   endtask

   task automatic host_write(input apb_sub_pkg::addr_t addr, input apb_sub_pkg::data_t wdata,
                             output apb_sub_pkg::host_rsp_t got);
      int lat;
      send_request(addr, wdata, 1'b1);
      wait_response(got, lat);
      @(posedge clk);
      #10;
   endtask

   // Fields on the pad config bus must not move while valid waits for ready
   task automatic watch_reg_request(input apb_sub_pkg::reg_req_t exp);
      @(negedge clk);
      while (!reg_req.valid) @(negedge clk);
      check_reg_req("reg_req_o", exp, reg_req);
      while (!reg_rsp.ready) begin
         @(negedge clk);
         check_reg_req("reg_req_o", exp, reg_req);
      end
   endtask

   task automatic reset_defaults;
      apb_sub_pkg::host_rsp_t got;
      int lat;
      check_error("rsp_valid_o", 1'b0, rsp_valid);
      check_data("gpio_o", '0, apb_sub_pkg::data_t'(gpio_out));
      check_data("gpio_dir_o", '0, apb_sub_pkg::data_t'(gpio_dir));
      check_pwm("pwm_o", '0, pwm);
      check_error("reg_req_o.valid", 1'b0, reg_req.valid);
      host_read('h000, got, lat);
      check_data("rsp_o.rdata", '0, got.rdata);
      check_error("rsp_o.error", 1'b0, got.error);
      check_data("response latency", 32'd3, apb_sub_pkg::data_t'(lat));
   endtask

   task automatic gpio_registers;
      apb_sub_pkg::host_rsp_t got;
      int lat;
      host_write('h000, 32'h0000_00F0, got);
      check_error("rsp_o.error", 1'b0, got.error);
      host_write('h004, 32'h0000_00A5, got);
      check_error("rsp_o.error", 1'b0, got.error);
      host_read('h000, got, lat);
      check_data("rsp_o.rdata", 32'h0000_00F0, got.rdata);
      host_read('h004, got, lat);
      check_data("rsp_o.rdata", 32'h0000_00A5, got.rdata);
      check_data("gpio_dir_o", 32'h0000_00F0, apb_sub_pkg::data_t'(gpio_dir));
      check_data("gpio_o", 32'h0000_00A5, apb_sub_pkg::data_t'(gpio_out));
      gpio_in = 'h3C;
      repeat (3) @(posedge clk);
      #10;
      host_read('h008, got, lat);
      check_data("rsp_o.rdata", 32'h0000_003C, got.rdata);
      check_error("rsp_o.error", 1'b0, got.error);
      host_write('h008, 32'h0000_00FF, got);
      check_error("rsp_o.error", 1'b1, got.error);
   endtask

   task automatic pwm_duty_cycles;
      apb_sub_pkg::host_rsp_t got;
      int period [NUM_PWM];
      int duty [NUM_PWM];
      int high_cnt [NUM_PWM];
      int window [NUM_PWM];
      int expect_cnt;
      period = '{6, 5, 4, 0};
      duty   = '{2, 0, 4, 3};
      for (int n = 0; n < NUM_PWM; n++) begin
         host_write(apb_sub_pkg::addr_t'(`APB_SUB_PWM_BASE + 8 * n), period[n], got);
         check_error("rsp_o.error", 1'b0, got.error);
         host_write(apb_sub_pkg::addr_t'(`APB_SUB_PWM_BASE + 8 * n + 4), duty[n], got);
         check_error("rsp_o.error", 1'b0, got.error);
         high_cnt[n] = 0;
         window[n]   = (period[n] == 0) ? 32 : 4 * period[n];
      end
      check_pwm("pwm_o", '0, pwm);
      host_write(apb_sub_pkg::addr_t'(`APB_SUB_PWM_BASE + 'hF0), 32'd1, got);
      check_error("rsp_o.error", 1'b0, got.error);
      // Output is periodic, so any run of 4 periods holds 4 high phases
      for (int i = 0; i < 32; i++) begin
         @(negedge clk);
         for (int n = 0; n < NUM_PWM; n++) begin
            if ((i < window[n]) && pwm[n]) high_cnt[n]++;
         end
      end
      for (int n = 0; n < NUM_PWM; n++) begin
         expect_cnt = 4 * ((duty[n] < period[n]) ? duty[n] : period[n]);
         check_data($sformatf("pwm_o[%0d] high cycles", n), apb_sub_pkg::data_t'(expect_cnt),
                    apb_sub_pkg::data_t'(high_cnt[n]));
      end
      @(posedge clk);
      #10;
      host_write(apb_sub_pkg::addr_t'(`APB_SUB_PWM_BASE + 'hF0), 32'd0, got);
      check_pwm("pwm_o", '0, pwm);
   endtask

   task automatic reg_bus_transfers;
      apb_sub_pkg::host_rsp_t got;
      apb_sub_pkg::reg_req_t  exp_req;
      int lat;
      reg_err_model = 1'b0;
      exp_req.addr  = 'h034;
      exp_req.wdata = 32'h1234_5678;
      exp_req.write = 1'b1;
      exp_req.valid = 1'b1;
      send_request('h234, 32'h1234_5678, 1'b1);
      watch_reg_request(exp_req);
      wait_response(got, lat);
      check_error("rsp_o.error", 1'b0, got.error);
      @(posedge clk);
      #10;
      reg_rdata_model = 32'hCAFE_0123;
      exp_req.addr    = 'h010;
      exp_req.wdata   = '0;
      exp_req.write   = 1'b0;
      send_request('h210, '0, 1'b0);
      watch_reg_request(exp_req);
      wait_response(got, lat);
      check_data("rsp_o.rdata", 32'hCAFE_0123, got.rdata);
      check_error("rsp_o.error", 1'b0, got.error);
      @(posedge clk);
      #10;
      reg_err_model = 1'b1;
      host_write('h2FC, 32'h0000_0001, got);
      check_error("rsp_o.error", 1'b1, got.error);
      reg_err_model = 1'b0;
   endtask

   task automatic unmapped_backpressure;
      apb_sub_pkg::host_rsp_t got;
      apb_sub_pkg::host_rsp_t held;
      int lat;
      host_read('h300, got, lat);
      check_data("rsp_o.rdata", '0, got.rdata);
      check_error("rsp_o.error", 1'b1, got.error);
      rsp_ready = 1'b0;
      send_request('h3F0, 32'hDEAD_BEEF, 1'b1);
      wait_response(held, lat);
      check_data("rsp_o.rdata", '0, held.rdata);
      check_error("rsp_o.error", 1'b1, held.error);
      @(posedge clk);
      #10;
      // A second request waits behind the held response
      req_valid = 1'b1;
      req.addr  = 'h004;
      req.wdata = '0;
      req.write = 1'b0;
      repeat (5) begin
         @(negedge clk);
         check_error("rsp_valid_o", 1'b1, rsp_valid);
         check_data("rsp_o.rdata", '0, rsp.rdata);
         check_error("rsp_o.error", 1'b1, rsp.error);
         if (req_ready) begin
            $display("Request accepted at %0t ns while a response was still held", $time);
            other_errs++;
         end
      end
      @(posedge clk);
      #10;
      rsp_ready = 1'b1;
      send_request('h004, '0, 1'b0);
      wait_response(got, lat);
      // Output register still holds the value from the GPIO test
      check_data("rsp_o.rdata", 32'h0000_00A5, got.rdata);
      check_error("rsp_o.error", 1'b0, got.error);
      @(posedge clk);
      #10;
   endtask

   initial begin
      seed            = 90;
      value_errs      = 0;
      other_errs      = 0;
      cycle_cnt       = 0;
      arst_n          = 1'b0;
      req_valid       = 1'b0;
      req             = '0;
      rsp_ready       = 1'b1;
      gpio_in         = '0;
      reg_rsp         = '0;
      reg_busy        = 1'b0;
      reg_delay       = 0;
      reg_rdata_model = '0;
      reg_err_model   = 1'b0;
      repeat (5) @(posedge clk);
      #10;
      arst_n = 1'b1;
      reset_defaults();
      gpio_registers();
      pwm_duty_cycles();
      reg_bus_transfers();
      unmapped_backpressure();
      repeat (2) @(posedge clk);
      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if ((value_errs + other_errs) == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
